// ==== common/rp_defines.svh ====
/*
  Shared sizing macros for the scope core
  Channel counts, sample and gain widths, calibration shift
  GPIO and LED widths, bus address width, identification word
*/

`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Channel counts
////////////////////////////////////////////////////////////////////////////

`define RP_MNA 2            // Acquisition channels
`define RP_MNG 2            // Generator channels

////////////////////////////////////////////////////////////////////////////
// Data path widths
////////////////////////////////////////////////////////////////////////////

`define RP_DW 14            // ADC and DAC sample width
`define RP_MW 16            // Calibration gain width
`define RP_CAL_SHIFT 13     // Gain fraction bits, 8192 is unity

// Peripheral and bus widths
`define RP_GDW 16           // Expansion GPIO pins
`define RP_LW 8             // LEDs
`define RP_AW 8             // Word address

`define RP_ID 32'h5250_0001 // Returned by the ID register

`endif

// ==== common/rp_regs_pkg.sv ====
/*
  Register map types
  Bus data word and the word address enum of the setting registers
*/

`include "rp_defines.svh"

package rp_regs_pkg;

  // Bus data word
  typedef logic [31:0] reg_data_t;

  // Word addresses of the register bank
  typedef enum logic [`RP_AW-1:0] {
    REG_ID       = 'h00,  // Identification, read only
    REG_MUX      = 'h01,  // Loop bits low, gen bits above
    REG_ADC_MUL0 = 'h02,  // ADC ch0 gain
    REG_ADC_SUM0 = 'h03,  // ADC ch0 offset
    REG_ADC_MUL1 = 'h04,  // ADC ch1 gain
    REG_ADC_SUM1 = 'h05,  // ADC ch1 offset
    REG_DAC_MUL0 = 'h06,  // DAC ch0 gain
    REG_DAC_SUM0 = 'h07,  // DAC ch0 offset
    REG_DAC_MUL1 = 'h08,  // DAC ch1 gain
    REG_DAC_SUM1 = 'h09,  // DAC ch1 offset
    REG_GEN0     = 'h0A,  // Generator level ch0
    REG_GEN1     = 'h0B,  // Generator level ch1
    REG_GPIO_OUT = 'h0C,  // Pin output values
    REG_GPIO_DIR = 'h0D,  // 1 = output
    REG_GPIO_IN  = 'h0E,  // Synchronized pins, read only
    REG_LED      = 'h0F   // LED values
  } reg_addr_e;

endpackage : rp_regs_pkg

// ==== common/rp_dsp_pkg.sv ====
/*
  Signal path types
  Sample, calibration gain and offset, DAC source selection
*/

`include "rp_defines.svh"

package rp_dsp_pkg;

  // Two's complement sample as seen by ADC and DAC
  typedef logic signed [`RP_DW-1:0] smp_t;

  // Gain with RP_CAL_SHIFT fraction bits
  typedef logic signed [`RP_MW-1:0] cal_mul_t;

  // Offset in sample LSBs
  typedef logic signed [`RP_DW-1:0] cal_sum_t;

  // DAC source per generator channel
  typedef enum logic [1:0] {
    SRC_ZERO = 2'd0,  // Silence
    SRC_LOOP = 2'd1,  // Calibrated ADC loopback
    SRC_GEN  = 2'd2   // Register-held level
  } src_e;

endpackage : rp_dsp_pkg

// ==== calib/rp_calib.sv ====
/*
  Per-channel calibration pipeline
  Input register, scaled gain product, offset add with 14-bit saturation
  Three cycles of latency, one sample per cycle
*/

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_calib (
  input  logic                  adc_clk,
  input  logic                  adc_rst,
  input  rp_dsp_pkg::smp_t      dat_i,    // Raw sample
  input  rp_dsp_pkg::cal_mul_t  mul_i,    // Gain, 8192 = 1.0
  input  rp_dsp_pkg::cal_sum_t  sum_i,    // Offset
  output rp_dsp_pkg::smp_t      dat_o     // Calibrated sample
);

  localparam int unsigned PW = `RP_DW + `RP_MW;     // Full product
  localparam int unsigned SW = PW - `RP_CAL_SHIFT;  // After fraction drop
  localparam int unsigned AW = SW + 1;              // Room for offset carry

  // Output range limits
  localparam logic signed [AW-1:0] SAT_MAX = 2**(`RP_DW-1) - 1;
  localparam logic signed [AW-1:0] SAT_MIN = -(2**(`RP_DW-1));

  rp_dsp_pkg::smp_t     dat_q;  // Stage 1
  logic signed [PW-1:0] prod;
  logic signed [SW-1:0] scl_q;  // Stage 2
  logic signed [AW-1:0] acc;

  assign prod = dat_q * mul_i;  // Signed, no overflow at full width
  assign acc  = scl_q + sum_i;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge adc_rst) begin
    if (adc_rst) begin
      dat_q <= '0;
      scl_q <= '0;
      dat_o <= '0;
    end else begin
      dat_q <= dat_i;
      scl_q <= SW'(prod >>> `RP_CAL_SHIFT);  // Arithmetic, keeps sign
      // Clamp to DAC/ADC code range
      if (acc > SAT_MAX) begin
        dat_o <= SAT_MAX[`RP_DW-1:0];
      end else if (acc < SAT_MIN) begin
        dat_o <= SAT_MIN[`RP_DW-1:0];
      end else begin
        dat_o <= acc[`RP_DW-1:0];
      end
    end
  end

endmodule : rp_calib

// ==== source/rp_sys_regs.sv ====
/*
  Setting register bank on the strobe bus
  Calibration, DAC source, generator, GPIO and LED registers
  Registered read decode with a one-cycle acknowledge
*/

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_sys_regs (
  input  logic                                    adc_clk,
  input  logic                                    adc_rst,
  // Strobe bus
  input  logic                                    bus_wen_i,
  input  logic                                    bus_ren_i,
  input  rp_regs_pkg::reg_addr_e                  bus_addr_i,
  input  rp_regs_pkg::reg_data_t                  bus_wdata_i,
  output rp_regs_pkg::reg_data_t                  bus_rdata_o,
  output logic                                    bus_rack_o,
  // Calibration settings
  output rp_dsp_pkg::cal_mul_t [`RP_MNA-1:0]      adc_mul_o,
  output rp_dsp_pkg::cal_sum_t [`RP_MNA-1:0]      adc_sum_o,
  output rp_dsp_pkg::cal_mul_t [`RP_MNG-1:0]      dac_mul_o,
  output rp_dsp_pkg::cal_sum_t [`RP_MNG-1:0]      dac_sum_o,
  // DAC source and generator levels
  output rp_dsp_pkg::src_e     [`RP_MNG-1:0]      src_o,
  output rp_dsp_pkg::smp_t     [`RP_MNG-1:0]      gen_o,
  // GPIO and LED
  input  logic                 [`RP_GDW-1:0]      gpio_i,
  output logic                 [`RP_GDW-1:0]      gpio_o,
  output logic                 [`RP_GDW-1:0]      gpio_t_o,  // 1 = input
  output logic                 [`RP_LW-1:0]       led_o
);

  logic [`RP_MNG-1:0]     mux_loop;  // ADC loopback per channel
  logic [`RP_MNG-1:0]     mux_gen;   // Generator level per channel
  logic [`RP_GDW-1:0]     gpio_meta;
  logic [`RP_GDW-1:0]     gpio_sync;
  rp_regs_pkg::reg_data_t rdata;

  // Loop beats gen, neither gives silence
  always_comb begin
    for (int i = 0; i < `RP_MNG; i++) begin
      src_o[i] = mux_loop[i] ? rp_dsp_pkg::SRC_LOOP :
                 mux_gen[i]  ? rp_dsp_pkg::SRC_GEN  : rp_dsp_pkg::SRC_ZERO;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge adc_rst) begin
    if (adc_rst) begin
      mux_loop  <= '0;
      mux_gen   <= '0;
      adc_mul_o <= {`RP_MNA{rp_dsp_pkg::cal_mul_t'(1 << `RP_CAL_SHIFT)}};  // Unity
      adc_sum_o <= '0;
      dac_mul_o <= {`RP_MNG{rp_dsp_pkg::cal_mul_t'(1 << `RP_CAL_SHIFT)}};
      dac_sum_o <= '0;
      gen_o     <= '0;
      gpio_o    <= '0;
      gpio_t_o  <= '1;  // All pins start as inputs
      led_o     <= '0;
    end else if (bus_wen_i) begin
      case (bus_addr_i)
        rp_regs_pkg::REG_MUX: begin
          mux_loop <= bus_wdata_i[`RP_MNG-1:0];
          mux_gen  <= bus_wdata_i[2*`RP_MNG-1:`RP_MNG];
        end
        rp_regs_pkg::REG_ADC_MUL0: adc_mul_o[0] <= bus_wdata_i[`RP_MW-1:0];
        rp_regs_pkg::REG_ADC_SUM0: adc_sum_o[0] <= bus_wdata_i[`RP_DW-1:0];
        rp_regs_pkg::REG_ADC_MUL1: adc_mul_o[1] <= bus_wdata_i[`RP_MW-1:0];
        rp_regs_pkg::REG_ADC_SUM1: adc_sum_o[1] <= bus_wdata_i[`RP_DW-1:0];
        rp_regs_pkg::REG_DAC_MUL0: dac_mul_o[0] <= bus_wdata_i[`RP_MW-1:0];
        rp_regs_pkg::REG_DAC_SUM0: dac_sum_o[0] <= bus_wdata_i[`RP_DW-1:0];
        rp_regs_pkg::REG_DAC_MUL1: dac_mul_o[1] <= bus_wdata_i[`RP_MW-1:0];
        rp_regs_pkg::REG_DAC_SUM1: dac_sum_o[1] <= bus_wdata_i[`RP_DW-1:0];
        rp_regs_pkg::REG_GEN0:     gen_o[0]     <= bus_wdata_i[`RP_DW-1:0];
        rp_regs_pkg::REG_GEN1:     gen_o[1]     <= bus_wdata_i[`RP_DW-1:0];
        rp_regs_pkg::REG_GPIO_OUT: gpio_o       <= bus_wdata_i[`RP_GDW-1:0];
        rp_regs_pkg::REG_GPIO_DIR: gpio_t_o     <= ~bus_wdata_i[`RP_GDW-1:0];
        rp_regs_pkg::REG_LED:      led_o        <= bus_wdata_i[`RP_LW-1:0];
        default: ;  // ID, GPIO_IN and holes ignore writes
      endcase
    end
  end

  // Two-flop synchronizer on the pins
  always_ff @(posedge adc_clk, posedge adc_rst) begin
    if (adc_rst) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_i;
      gpio_sync <= gpio_meta;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////////////////////////////////////////

  // Signed fields come back sign extended
  always_comb begin
    case (bus_addr_i)
      rp_regs_pkg::REG_ID:       rdata = `RP_ID;
      rp_regs_pkg::REG_MUX:      rdata = {{(32-2*`RP_MNG){1'b0}}, mux_gen, mux_loop};
      rp_regs_pkg::REG_ADC_MUL0: rdata = 32'(signed'(adc_mul_o[0]));
      rp_regs_pkg::REG_ADC_SUM0: rdata = 32'(signed'(adc_sum_o[0]));
      rp_regs_pkg::REG_ADC_MUL1: rdata = 32'(signed'(adc_mul_o[1]));
      rp_regs_pkg::REG_ADC_SUM1: rdata = 32'(signed'(adc_sum_o[1]));
      rp_regs_pkg::REG_DAC_MUL0: rdata = 32'(signed'(dac_mul_o[0]));
      rp_regs_pkg::REG_DAC_SUM0: rdata = 32'(signed'(dac_sum_o[0]));
      rp_regs_pkg::REG_DAC_MUL1: rdata = 32'(signed'(dac_mul_o[1]));
      rp_regs_pkg::REG_DAC_SUM1: rdata = 32'(signed'(dac_sum_o[1]));
      rp_regs_pkg::REG_GEN0:     rdata = 32'(signed'(gen_o[0]));
      rp_regs_pkg::REG_GEN1:     rdata = 32'(signed'(gen_o[1]));
      rp_regs_pkg::REG_GPIO_OUT: rdata = {{(32-`RP_GDW){1'b0}}, gpio_o};
      rp_regs_pkg::REG_GPIO_DIR: rdata = {{(32-`RP_GDW){1'b0}}, ~gpio_t_o};
      rp_regs_pkg::REG_GPIO_IN:  rdata = {{(32-`RP_GDW){1'b0}}, gpio_sync};
      rp_regs_pkg::REG_LED:      rdata = {{(32-`RP_LW){1'b0}}, led_o};
      default:                   rdata = '0;  // Unmapped
    endcase
  end

  // Acknowledge one cycle after the strobe
  always_ff @(posedge adc_clk, posedge adc_rst) begin
    if (adc_rst) begin
      bus_rack_o <= 1'b0;
    end else begin
      bus_rack_o <= bus_ren_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (bus_ren_i) begin
      bus_rdata_o <= rdata;  // Held until the next read
    end
  end

endmodule : rp_sys_regs

// ==== source/rp_stream_mux.sv ====
/*
  DAC source selector
  Registers loopback, generator level or zero for each generator channel
*/

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_stream_mux (
  input  logic                                adc_clk,
  input  logic                                adc_rst,
  input  rp_dsp_pkg::smp_t [`RP_MNA-1:0]      adc_smp_i,  // Calibrated ADC
  input  rp_dsp_pkg::smp_t [`RP_MNG-1:0]      gen_i,      // Generator levels
  input  rp_dsp_pkg::src_e [`RP_MNG-1:0]      src_i,      // Per-channel source
  output rp_dsp_pkg::smp_t [`RP_MNG-1:0]      dac_smp_o   // Toward DAC calibration
);

  ////////////////////////////////////////////////////////////////////////////
  // One register stage per channel
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge adc_rst) begin
    if (adc_rst) begin
      dac_smp_o <= '0;
    end else begin
      for (int i = 0; i < `RP_MNG; i++) begin
        case (src_i[i])
          rp_dsp_pkg::SRC_LOOP: dac_smp_o[i] <= adc_smp_i[i];  // Same index
          rp_dsp_pkg::SRC_GEN:  dac_smp_o[i] <= gen_i[i];
          default:              dac_smp_o[i] <= '0;            // Silence
        endcase
      end
    end
  end

endmodule : rp_stream_mux

// ==== source/rp_top.sv ====
/*
  Scope and generator core top level
  Reset release flop, register bank, ADC and DAC calibration
  DAC source selection, GPIO and LED ports
*/

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_top (
  input  logic                                adc_clk,
  input  logic                                top_rst,      // Async, active high
  // Strobe bus
  input  logic                                bus_wen_i,
  input  logic                                bus_ren_i,
  input  rp_regs_pkg::reg_addr_e              bus_addr_i,
  input  rp_regs_pkg::reg_data_t              bus_wdata_i,
  output rp_regs_pkg::reg_data_t              bus_rdata_o,
  output logic                                bus_rack_o,
  // ADC and DAC samples
  input  rp_dsp_pkg::smp_t [`RP_MNA-1:0]      adc_dat_i,
  output rp_dsp_pkg::smp_t [`RP_MNA-1:0]      adc_smp_o,    // Calibrated ADC
  output rp_dsp_pkg::smp_t [`RP_MNG-1:0]      dac_dat_o,
  // Expansion GPIO and LED
  input  logic             [`RP_GDW-1:0]      gpio_i,
  output logic             [`RP_GDW-1:0]      gpio_o,
  output logic             [`RP_GDW-1:0]      gpio_t_o,     // 1 = input
  output logic             [`RP_LW-1:0]       led_o
);

  logic                                  adc_rst;
  rp_dsp_pkg::cal_mul_t [`RP_MNA-1:0]    adc_mul;
  rp_dsp_pkg::cal_sum_t [`RP_MNA-1:0]    adc_sum;
  rp_dsp_pkg::cal_mul_t [`RP_MNG-1:0]    dac_mul;
  rp_dsp_pkg::cal_sum_t [`RP_MNG-1:0]    dac_sum;
  rp_dsp_pkg::cal_sum_t [`RP_MNG-1:0]    dac_sum_g;  // Offset seen by DAC calibration
  rp_dsp_pkg::src_e     [`RP_MNG-1:0]    src;
  rp_dsp_pkg::smp_t     [`RP_MNG-1:0]    gen;
  rp_dsp_pkg::smp_t     [`RP_MNG-1:0]    dac_smp;  // Selected, uncalibrated

  ////////////////////////////////////////////////////////////////////////////
  // Reset release
  ////////////////////////////////////////////////////////////////////////////

  // Asserts at once and drops on the first clock after top_rst falls
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_rst <= 1'b1;
    end else begin
      adc_rst <= 1'b0;
    end
  end

  rp_sys_regs i_regs (
    .adc_clk     (adc_clk),
    .adc_rst     (adc_rst),
    .bus_wen_i   (bus_wen_i),
    .bus_ren_i   (bus_ren_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rdata_o (bus_rdata_o),
    .bus_rack_o  (bus_rack_o),
    .adc_mul_o   (adc_mul),
    .adc_sum_o   (adc_sum),
    .dac_mul_o   (dac_mul),
    .dac_sum_o   (dac_sum),
    .src_o       (src),
    .gen_o       (gen),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_t_o    (gpio_t_o),
    .led_o       (led_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Signal path
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `RP_MNA; i++) begin : g_adc
    rp_calib i_cal (
      .adc_clk (adc_clk),
      .adc_rst (adc_rst),
      .dat_i   (adc_dat_i[i]),
      .mul_i   (adc_mul[i]),
      .sum_i   (adc_sum[i]),
      .dat_o   (adc_smp_o[i])  // Also feeds loopback
    );
  end

  rp_stream_mux i_mux (
    .adc_clk   (adc_clk),
    .adc_rst   (adc_rst),
    .adc_smp_i (adc_smp_o),
    .gen_i     (gen),
    .src_i     (src),
    .dac_smp_o (dac_smp)
  );

  // Silent channels drop the offset so the DAC sits at code zero
  always_comb begin
    for (int i = 0; i < `RP_MNG; i++) begin
      dac_sum_g[i] = (src[i] == rp_dsp_pkg::SRC_ZERO) ? rp_dsp_pkg::cal_sum_t'(0) : dac_sum[i];
    end
  end

  for (genvar i = 0; i < `RP_MNG; i++) begin : g_dac
    rp_calib i_cal (
      .adc_clk (adc_clk),
      .adc_rst (adc_rst),
      .dat_i   (dac_smp[i]),
      .mul_i   (dac_mul[i]),
      .sum_i   (dac_sum_g[i]),
      .dat_o   (dac_dat_o[i])
    );
  end

endmodule : rp_top

// ==== bench/rp_top_props.sv ====
/*
  Bus and reset properties of the core top level
  Read acknowledge timing, quiet outputs and input pins during reset
*/

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_top_props (
  input logic                            adc_clk,
  input logic                            adc_rst,
  input logic                            bus_ren_i,
  input logic                            bus_rack_i,
  input rp_dsp_pkg::smp_t [`RP_MNG-1:0]  dac_dat_i,
  input logic             [`RP_GDW-1:0]  gpio_t_i
);

  // Ack is the read strobe delayed by one cycle
  a_rack: assert property (@(posedge adc_clk) disable iff (adc_rst)
    bus_rack_i == $past(bus_ren_i))
    else $error("bus_rack_o does not follow bus_ren_i by one cycle");

  a_rst_quiet: assert property (@(posedge adc_clk)
    adc_rst |-> (!bus_rack_i && dac_dat_i == '0))  // No ack, silent DAC
    else $error("bus_rack_o or dac_dat_o nonzero during reset");

  a_rst_gpio: assert property (@(posedge adc_clk) adc_rst |-> &gpio_t_i)
    else $error("gpio_t_o not all inputs during reset");

endmodule : rp_top_props

bind rp_top rp_top_props i_props (
  .adc_clk    (adc_clk),
  .adc_rst    (adc_rst),     // Internal release flop
  .bus_ren_i  (bus_ren_i),
  .bus_rack_i (bus_rack_o),
  .dac_dat_i  (dac_dat_o),
  .gpio_t_i   (gpio_t_o)
);

// ==== bench/rp_top_tb.sv ====
/*
  Testbench for the scope core top level
  Opcode records from the stim file drive the strobe bus, ADC and GPIO pins
  Typed compare tasks, reference calibration, per-test report, cycle timeout
*/

`timescale 1ns/1ps

`include "rp_defines.svh"

module rp_top_tb;

  localparam int REC_MAX = 128;  // Stim records of four words each

  // Stim opcodes
  localparam logic [7:0] OP_END       = 8'h00;
  localparam logic [7:0] OP_WR        = 8'h01;
  localparam logic [7:0] OP_RD        = 8'h02;
  localparam logic [7:0] OP_ADC       = 8'h03;
  localparam logic [7:0] OP_WAIT      = 8'h04;
  localparam logic [7:0] OP_CHK_ADC   = 8'h05;
  localparam logic [7:0] OP_CHK_DAC   = 8'h06;
  localparam logic [7:0] OP_CHK_GPIO  = 8'h07;
  localparam logic [7:0] OP_CHK_GPIOT = 8'h08;
  localparam logic [7:0] OP_CHK_LED   = 8'h09;
  localparam logic [7:0] OP_TEST      = 8'h0A;
  localparam logic [7:0] OP_LOOP      = 8'h0B;
  localparam logic [7:0] OP_GPIN      = 8'h0C;
  localparam logic [7:0] OP_WRRD      = 8'h0D;

  logic                                adc_clk;
  logic                                top_rst;
  logic                                bus_wen_i;
  logic                                bus_ren_i;
  rp_regs_pkg::reg_addr_e              bus_addr_i;
  rp_regs_pkg::reg_data_t              bus_wdata_i;
  rp_regs_pkg::reg_data_t              bus_rdata_o;
  logic                                bus_rack_o;
  rp_dsp_pkg::smp_t [`RP_MNA-1:0]      adc_dat_i;
  rp_dsp_pkg::smp_t [`RP_MNA-1:0]      adc_smp_o;
  rp_dsp_pkg::smp_t [`RP_MNG-1:0]      dac_dat_o;
  logic             [`RP_GDW-1:0]      gpio_i;
  logic             [`RP_GDW-1:0]      gpio_o;
  logic             [`RP_GDW-1:0]      gpio_t_o;
  logic             [`RP_LW-1:0]       led_o;

  logic [31:0] stim [0:4*REC_MAX-1];
  int          n_rec;
  int          cycles = 0;
  int          limit = 0;       // Zero until the stim is counted
  int          errs = 0;        // Mismatches in the running test
  int          tests_ok = 0;
  int          tests_bad = 0;
  integer      seed = 32'h5b0;

  // Calibration settings as last written for the loopback reference
  rp_dsp_pkg::cal_mul_t adc_mul_s [`RP_MNA];
  rp_dsp_pkg::cal_sum_t adc_sum_s [`RP_MNA];
  rp_dsp_pkg::cal_mul_t dac_mul_s [`RP_MNG];
  rp_dsp_pkg::cal_sum_t dac_sum_s [`RP_MNG];

  rp_top uut (.*);  // Port names match one to one

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  // Watchdog with a limit scaled to the stim length
  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reg(input string name, input rp_regs_pkg::reg_data_t exp,
                           input rp_regs_pkg::reg_data_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errs++;
    end
  endtask

  task automatic check_smp(input string name, input rp_dsp_pkg::smp_t exp,
                           input rp_dsp_pkg::smp_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      errs++;
    end
  endtask

  task automatic check_bits(input string name, input logic [`RP_GDW-1:0] exp,
                            input logic [`RP_GDW-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errs++;
    end
  endtask

  // Gain with 13 fraction bits, floor shift, offset, clamp to 14 bits
  function automatic rp_dsp_pkg::smp_t cal_model(input rp_dsp_pkg::smp_t s,
      input rp_dsp_pkg::cal_mul_t m, input rp_dsp_pkg::cal_sum_t o);
    longint v;
    v = (longint'(s) * longint'(m)) >>> `RP_CAL_SHIFT;
    v = v + longint'(o);
    if (v > 2**(`RP_DW-1) - 1) begin
      v = 2**(`RP_DW-1) - 1;
    end else if (v < -(2**(`RP_DW-1))) begin
      v = -(2**(`RP_DW-1));
    end
    return rp_dsp_pkg::smp_t'(v);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus and stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [7:0] addr, input rp_regs_pkg::reg_data_t data);
    @(posedge adc_clk);
    bus_wen_i   <= 1'b1;
    bus_addr_i  <= rp_regs_pkg::reg_addr_e'(addr);
    bus_wdata_i <= data;
    @(posedge adc_clk);
    bus_wen_i   <= 1'b0;
    case (rp_regs_pkg::reg_addr_e'(addr))  // Track calibration for the reference
      rp_regs_pkg::REG_ADC_MUL0: adc_mul_s[0] = data[`RP_MW-1:0];
      rp_regs_pkg::REG_ADC_SUM0: adc_sum_s[0] = data[`RP_DW-1:0];
      rp_regs_pkg::REG_ADC_MUL1: adc_mul_s[1] = data[`RP_MW-1:0];
      rp_regs_pkg::REG_ADC_SUM1: adc_sum_s[1] = data[`RP_DW-1:0];
      rp_regs_pkg::REG_DAC_MUL0: dac_mul_s[0] = data[`RP_MW-1:0];
      rp_regs_pkg::REG_DAC_SUM0: dac_sum_s[0] = data[`RP_DW-1:0];
      rp_regs_pkg::REG_DAC_MUL1: dac_mul_s[1] = data[`RP_MW-1:0];
      rp_regs_pkg::REG_DAC_SUM1: dac_sum_s[1] = data[`RP_DW-1:0];
      default: ;
    endcase
  endtask

  task automatic bus_read(input logic [7:0] addr, output rp_regs_pkg::reg_data_t data);
    int wait_cnt;
    @(posedge adc_clk);
    bus_ren_i  <= 1'b1;
    bus_addr_i <= rp_regs_pkg::reg_addr_e'(addr);
    @(posedge adc_clk);
    bus_ren_i  <= 1'b0;
    wait_cnt = 0;
    @(negedge adc_clk);
    while (!bus_rack_o && wait_cnt < 8) begin  // Bounded wait for the ack
      @(negedge adc_clk);
      wait_cnt++;
    end
    if (!bus_rack_o) begin
      $display("Read of address %h at %0t ns got no acknowledge", addr, $time);
      errs++;
    end
    data = bus_rdata_o;
  endtask

  // Random ADC samples checked after the ADC and through the DAC path
  task automatic loop_check(input int ch, input int count);
    rp_dsp_pkg::smp_t s;
    rp_dsp_pkg::smp_t a;
    repeat (count) begin
      s = rp_dsp_pkg::smp_t'($random(seed));
      @(posedge adc_clk);
      adc_dat_i[ch] <= s;
      repeat (10) @(posedge adc_clk);  // Settle past the 7-cycle path
      @(negedge adc_clk);
      a = cal_model(s, adc_mul_s[ch], adc_sum_s[ch]);
      check_smp($sformatf("adc_smp_o[%0d]", ch), a, adc_smp_o[ch]);
      check_smp($sformatf("dac_dat_o[%0d]", ch), cal_model(a, dac_mul_s[ch], dac_sum_s[ch]),
                dac_dat_o[ch]);
    end
  endtask

  task automatic end_test(input int num);
    if (errs == 0) begin
      $display("Test %0d passed", num);
      tests_ok++;
    end else begin
      $display("Test %0d failed with %0d mismatches", num, errs);
      tests_bad++;
    end
    errs = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stim interpreter
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [7:0]             op;
    logic [7:0]             addr;
    logic [31:0]            val;
    logic [31:0]            exp;
    rp_regs_pkg::reg_data_t rd;
    top_rst     = 1'b1;
    bus_wen_i   = 1'b0;
    bus_ren_i   = 1'b0;
    bus_addr_i  = rp_regs_pkg::REG_ID;
    bus_wdata_i = '0;
    adc_dat_i   = '0;
    gpio_i      = '0;
    for (int i = 0; i < `RP_MNA; i++) begin
      adc_mul_s[i] = rp_dsp_pkg::cal_mul_t'(1 << `RP_CAL_SHIFT);  // Unity after reset
      adc_sum_s[i] = '0;
    end
    for (int i = 0; i < `RP_MNG; i++) begin
      dac_mul_s[i] = rp_dsp_pkg::cal_mul_t'(1 << `RP_CAL_SHIFT);
      dac_sum_s[i] = '0;
    end
    for (int i = 0; i < 4*REC_MAX; i++) begin
      stim[i] = '0;
    end
    $readmemh("bench/rp_stim.txt", stim);
    n_rec = 0;
    while (n_rec < REC_MAX && stim[4*n_rec][7:0] != OP_END) begin
      n_rec++;
    end
    limit = 20 * (n_rec + 1) + 200;
    repeat (4) @(posedge adc_clk);
    top_rst <= 1'b0;
    for (int r = 0; r < n_rec; r++) begin
      op   = stim[4*r][7:0];
      addr = stim[4*r+1][7:0];
      val  = stim[4*r+2];
      exp  = stim[4*r+3];
      case (op)
        OP_WR: bus_write(addr, val);
        OP_RD: begin
          bus_read(addr, rd);
          check_reg($sformatf("bus_rdata_o@%h", addr), exp, rd);
        end
        OP_WRRD: begin
          bus_write(addr, val);
          bus_read(addr, rd);
          check_reg($sformatf("bus_rdata_o@%h", addr), exp, rd);
        end
        OP_ADC: begin
          @(posedge adc_clk);
          adc_dat_i[addr[0]] <= rp_dsp_pkg::smp_t'(val);
        end
        OP_GPIN: begin
          @(posedge adc_clk);
          gpio_i <= val[`RP_GDW-1:0];
        end
        OP_WAIT: repeat (val) @(posedge adc_clk);
        OP_CHK_ADC: begin
          @(negedge adc_clk);
          check_smp($sformatf("adc_smp_o[%0d]", addr[0]), exp[`RP_DW-1:0],
                    adc_smp_o[addr[0]]);
        end
        OP_CHK_DAC: begin
          @(negedge adc_clk);
          check_smp($sformatf("dac_dat_o[%0d]", addr[0]), exp[`RP_DW-1:0],
                    dac_dat_o[addr[0]]);
        end
        OP_CHK_GPIO: begin
          @(negedge adc_clk);
          check_bits("gpio_o", exp[`RP_GDW-1:0], gpio_o);
        end
        OP_CHK_GPIOT: begin
          @(negedge adc_clk);
          check_bits("gpio_t_o", exp[`RP_GDW-1:0], gpio_t_o);
        end
        OP_CHK_LED: begin
          @(negedge adc_clk);
          check_bits("led_o", exp[`RP_GDW-1:0], {{(`RP_GDW-`RP_LW){1'b0}}, led_o});
        end
        OP_LOOP: loop_check(int'(addr[0]), int'(val));
        OP_TEST: end_test(int'(addr));
        default: begin
          $display("Stim record %0d holds unknown opcode %h", r, op);
          errs++;
        end
      endcase
    end
    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && errs == 0 && tests_ok > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : rp_top_tb

// ==== bench/rp_stim.txt ====
// Columns, all hex: opcode, address or channel, value, expected
// Ops 1 wr, 2 rd, 3 adc, 4 wait, 5-9 chk adc/dac/gpio/gpio_t/led, a end test
// Ops b random loopback (value = count), c gpio_i, d write and read back, 0 end
2 00 00000000 52500001
2 02 00000000 00002000
2 08 00000000 00002000
8 00 00000000 0000ffff
6 00 00000000 00000000
6 01 00000000 00000000
9 00 00000000 00000000
a 01 00000000 00000000
d 01 0000000f 0000000f
d 02 00001000 00001000
d 03 00000011 00000011
d 04 00001800 00001800
d 05 00000022 00000022
d 06 00003000 00003000
d 07 00000033 00000033
d 08 00004000 00004000
d 09 00000044 00000044
d 0a 00000555 00000555
d 0b 00000aaa 00000aaa
d 0c 0000a5a5 0000a5a5
d 0d 00005a5a 00005a5a
d 0f 000000c3 000000c3
d 0e 00001234 00000000
2 10 00000000 00000000
a 02 00000000 00000000
1 02 00004000 00000000
1 03 00000010 00000000
1 04 00001800 00000000
1 05 00003ffd 00000000
3 00 00000064 00000000
3 01 00003f9b 00000000
4 00 0000000a 00000000
5 00 00000000 000000d8
5 01 00000000 00003fb1
3 00 00001388 00000000
4 00 0000000a 00000000
5 00 00000000 00001fff
3 00 00002c78 00000000
4 00 0000000a 00000000
5 00 00000000 00002000
a 03 00000000 00000000
1 06 00001000 00000000
1 07 00000005 00000000
1 08 00002000 00000000
1 09 00000000 00000000
1 01 0000000f 00000000
4 00 0000000a 00000000
b 00 00000006 00000000
b 01 00000006 00000000
a 04 00000000 00000000
1 0a 00000100 00000000
1 0b 00003f00 00000000
1 01 0000000c 00000000
4 00 0000000a 00000000
6 00 00000000 00000085
6 01 00000000 00003f00
1 01 00000000 00000000
4 00 0000000a 00000000
6 00 00000000 00000000
6 01 00000000 00000000
a 05 00000000 00000000
1 0c 0000beef 00000000
1 0d 0000ff00 00000000
1 0f 0000005a 00000000
c 00 00003c3c 00000000
4 00 0000000a 00000000
7 00 00000000 0000beef
8 00 00000000 000000ff
9 00 00000000 0000005a
2 0e 00000000 00003c3c
a 06 00000000 00000000
0 00 00000000 00000000

// ==== list.f ====
+incdir+common
common/rp_regs_pkg.sv
common/rp_dsp_pkg.sv
calib/rp_calib.sv
source/rp_sys_regs.sv
source/rp_stream_mux.sv
source/rp_top.sv
bench/rp_top_props.sv
bench/rp_top_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := rp_top_tb
FLIST    := list.f
LOG      := sim.log
BIN      := obj_dir/V$(TOP)
FAIL_MSG := TEST FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
